// File: hdl/div_pkg.sv
// Shared types for the serial divider; width fixed at 32 bits, opcodes follow RISC-V DIV/DIVU/REM/REMU
`default_nettype none

package div_pkg;

    // Operand and result width
    localparam int xlen = 32;

    // Width of a bit index or a leading-zero count
    localparam int shamt_w = $clog2(xlen);

    // Bit 0 set means unsigned, bit 1 set means the remainder is returned
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_e;

    // Core sequencing states
    typedef enum logic [1:0] {
        S_IDLE   = 2'b00,
        S_ITER   = 2'b01,
        S_FINISH = 2'b10
    } div_state_e;

    // One division request as presented at the unit boundary
    typedef struct packed {
        div_op_e         op;
        logic [xlen-1:0] dividend;
        logic [xlen-1:0] divisor;
    } div_req_t;

    // Operands after magnitude extraction and alignment analysis
    typedef struct packed {
        logic [xlen-1:0]    dividend_mag;
        logic [xlen-1:0]    divisor_mag;
        logic               quot_neg;
        logic               rem_neg;
        logic               rem_sel;
        logic               div_zero;
        // Quotient is zero because the dividend is narrower than the divisor
        logic               early_out;
        logic [shamt_w-1:0] shift;
    } div_prep_t;

endpackage

`default_nettype wire

// File: hdl/find_first_one.sv
// Combinational leading-one finder, WIDTH must be at least 2; an all-zero input gives no_ones high
`default_nettype none

module find_first_one #(
    parameter int WIDTH = 32,
    parameter int FLIP  = 0
) (
    input  logic [WIDTH-1:0]         in,
    output logic [$clog2(WIDTH)-1:0] first_one,
    output logic                     no_ones
);

    localparam int LEVELS = $clog2(WIDTH);
    localparam int NODES  = 2 ** LEVELS;

    // Input in search order, bit 0 is looked at first
    logic [WIDTH-1:0] in_ord;

    // Heap-ordered tree with node 0 as root, children of node p sit at 2p+1 and 2p+2
    logic [NODES-2:0]             node_sel;
    logic [NODES-2:0][LEVELS-1:0] node_idx;

    // With FLIP set the MSB is searched first, so the result is a leading-zero count
    for (genvar i = 0; i < WIDTH; i++) begin : g_order
        assign in_ord[i] = (FLIP != 0) ? in[WIDTH-1-i] : in[i];
    end

    // Leaf level, each node covers two adjacent input bits
    for (genvar k = 0; k < NODES / 2; k++) begin : g_leaf
        localparam int N = NODES / 2 - 1 + k;
        if (2 * k + 1 < WIDTH) begin : g_pair
            assign node_sel[N] = in_ord[2*k] | in_ord[2*k+1];
            assign node_idx[N] = in_ord[2*k] ? LEVELS'(2 * k) : LEVELS'(2 * k + 1);
        end else if (2 * k < WIDTH) begin : g_single
            // Odd width leaves one bit without a partner
            assign node_sel[N] = in_ord[2*k];
            assign node_idx[N] = LEVELS'(2 * k);
        end else begin : g_empty
            // Padding beyond the input never holds a one
            assign node_sel[N] = 1'b0;
            assign node_idx[N] = '0;
        end
    end

    // Inner levels prefer the lower half whenever it holds a one
    for (genvar lv = 0; lv < LEVELS - 1; lv++) begin : g_level
        for (genvar n = 0; n < 2 ** lv; n++) begin : g_node
            localparam int P = 2 ** lv - 1 + n;
            localparam int C = 2 ** (lv + 1) - 1 + 2 * n;
            assign node_sel[P] = node_sel[C] | node_sel[C+1];
            assign node_idx[P] = node_sel[C] ? node_idx[C] : node_idx[C+1];
        end
    end

    assign first_one = node_idx[0];
    assign no_ones   = ~node_sel[0];

    // The root index must land on a one with only zeros before it in search order
    always_comb begin
        assert final (no_ones ? (in == '0)
                      : (in_ord[first_one] && ((in_ord << (WIDTH - int'(first_one))) == '0)))
            else $error("find_first_one: index %0d wrong for input %h", first_one, in);
    end

endmodule

`default_nettype wire

// File: hdl/div_operand_prep.sv
// Combinational request analysis, no latency; shift is only meaningful while early_out is low
`default_nettype none

module div_operand_prep import div_pkg::*; (
    input  div_req_t  req,
    output div_prep_t prep
);

    logic               is_signed;
    logic               a_neg;
    logic               b_neg;
    logic [xlen-1:0]    a_mag;
    logic [xlen-1:0]    b_mag;
    logic [shamt_w-1:0] lz_a;
    logic [shamt_w-1:0] lz_b;
    logic               a_zero;
    logic               b_zero;
    logic               early;

    // DIV and REM treat both operands as two's complement
    assign is_signed = (req.op == DIV) || (req.op == REM);
    assign a_neg     = is_signed & req.dividend[xlen-1];
    assign b_neg     = is_signed & req.divisor[xlen-1];

    // The most negative value maps onto itself, which is its correct unsigned magnitude
    assign a_mag = a_neg ? (~req.dividend + 1'b1) : req.dividend;
    assign b_mag = b_neg ? (~req.divisor + 1'b1) : req.divisor;

    // Leading-zero count of the dividend magnitude
    find_first_one #(
        .WIDTH (xlen),
        .FLIP  (1)
    ) u_lzc_dividend (
        .in        (a_mag),
        .first_one (lz_a),
        .no_ones   (a_zero)
    );

    // Leading-zero count of the divisor magnitude, an empty divisor is a divide by zero
    find_first_one #(
        .WIDTH (xlen),
        .FLIP  (1)
    ) u_lzc_divisor (
        .in        (b_mag),
        .first_one (lz_b),
        .no_ones   (b_zero)
    );

    // Fewer significant dividend bits than divisor bits means the quotient is zero
    assign early = a_zero | (lz_a > lz_b);

    always_comb begin
        prep.dividend_mag = a_mag;
        prep.divisor_mag  = b_mag;
        // Quotient sign follows the operand signs, but a zero divisor keeps all ones intact
        prep.quot_neg     = (a_neg ^ b_neg) & ~b_zero;
        // Remainder always carries the sign of the dividend
        prep.rem_neg      = a_neg;
        prep.rem_sel      = (req.op == REM) || (req.op == REMU);
        prep.div_zero     = b_zero;
        prep.early_out    = early;
        // Distance that puts the divisor MSB under the dividend MSB
        prep.shift        = early ? '0 : (lz_b - lz_a);
    end

endmodule

`default_nettype wire

// File: hdl/div_serial_core.sv
// One quotient bit per clock, 1 to 32 cycles to done; starts while busy are dropped silently
`default_nettype none

module div_serial_core import div_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  div_prep_t       prep,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] result
);

    div_state_e       state_q;
    logic [shamt_w:0] cnt_q;
    logic             quot_neg_q;
    logic             rem_neg_q;
    logic             rem_sel_q;
    logic             done_q;
    logic [xlen-1:0]  result_q;

    // Datapath registers
    logic [xlen-1:0] rem_q;
    logic [xlen-1:0] dvs_q;
    logic [xlen-1:0] quo_q;

    logic            accept;
    logic            skip_iter;
    logic            last_iter;
    logic            load_fin;
    logic            step_ge;
    logic [xlen-1:0] step_rem;
    logic [xlen-1:0] step_quo;
    logic [xlen-1:0] fin_quo;
    logic [xlen-1:0] fin_rem;
    logic            fin_qneg;
    logic            fin_rneg;
    logic            fin_rsel;
    logic            fin_dz;
    logic [xlen-1:0] quo_fix;
    logic [xlen-1:0] rem_fix;
    logic [xlen-1:0] result_d;

    assign accept    = start && (state_q == S_IDLE);
    // Zero quotient and divide by zero need no iterations at all
    assign skip_iter = prep.early_out | prep.div_zero;
    assign last_iter = (state_q == S_ITER) && (cnt_q == 1);

    // Result is loaded on every edge that enters S_FINISH, so done and result line up
    assign load_fin = (accept && skip_iter) || last_iter;

    // One restoring step, subtract when the aligned divisor fits
    always_comb begin
        step_ge  = rem_q >= dvs_q;
        step_rem = step_ge ? (rem_q - dvs_q) : rem_q;
        step_quo = {quo_q[xlen-2:0], step_ge};
    end

    // Final magnitudes come straight from prep on a skip, else from the last step
    always_comb begin
        if (state_q == S_IDLE) begin
            fin_quo  = '0;
            fin_rem  = prep.dividend_mag;
            fin_qneg = prep.quot_neg;
            fin_rneg = prep.rem_neg;
            fin_rsel = prep.rem_sel;
            fin_dz   = prep.div_zero;
        end else begin
            fin_quo  = step_quo;
            fin_rem  = step_rem;
            fin_qneg = quot_neg_q;
            fin_rneg = rem_neg_q;
            fin_rsel = rem_sel_q;
            // A zero divisor never reaches S_ITER
            fin_dz   = 1'b0;
        end
    end

    // Sign fixup, then the RISC-V divide-by-zero quotient
    always_comb begin
        quo_fix = fin_qneg ? (~fin_quo + 1'b1) : fin_quo;
        // Negating the dividend magnitude restores the original dividend on divide by zero
        rem_fix = fin_rneg ? (~fin_rem + 1'b1) : fin_rem;
        if (fin_dz) begin
            quo_fix = '1;
        end
        result_d = fin_rsel ? rem_fix : quo_fix;
    end

    // Control state and the result register
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= S_IDLE;
            cnt_q      <= '0;
            quot_neg_q <= 1'b0;
            rem_neg_q  <= 1'b0;
            rem_sel_q  <= 1'b0;
            done_q     <= 1'b0;
            result_q   <= '0;
        end else begin
            done_q <= load_fin;
            if (load_fin) begin
                result_q <= result_d;
            end
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        // Quotient bits exist at positions shift down to zero
                        cnt_q      <= {1'b0, prep.shift} + 1'b1;
                        quot_neg_q <= prep.quot_neg;
                        rem_neg_q  <= prep.rem_neg;
                        rem_sel_q  <= prep.rem_sel;
                        state_q    <= skip_iter ? S_FINISH : S_ITER;
                    end
                end
                S_ITER: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (last_iter) begin
                        state_q <= S_FINISH;
                    end
                end
                S_FINISH: begin
                    state_q <= S_IDLE;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Partial remainder, aligned divisor and quotient shift register
    always_ff @(posedge clk) begin
        if (accept) begin
            rem_q <= prep.dividend_mag;
            dvs_q <= prep.divisor_mag << prep.shift;
            quo_q <= '0;
        end else if (state_q == S_ITER) begin
            rem_q <= step_rem;
            dvs_q <= dvs_q >> 1;
            quo_q <= step_quo;
        end
    end

    assign busy   = (state_q != S_IDLE);
    assign done   = done_q;
    assign result = result_q;

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

    // Done only appears while a request is in flight
    a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy);

    // Every iteration still has a quotient bit left, and never more than xlen of them
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        (state_q == S_ITER) |-> (cnt_q != 0) && (cnt_q <= xlen));

    // A start during a division leaves the captured request alone
    a_start_busy: assert property (@(posedge clk) disable iff (rst)
        busy && start |=> $stable({quot_neg_q, rem_neg_q, rem_sel_q}));

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
// Serial divider top; req is sampled only with start while idle, one division in flight at a time
`default_nettype none

module div_unit import div_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  div_req_t        req,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] result
);

    // Prepared operands, valid in the same cycle as req
    div_prep_t prep;

    // Magnitudes, sign rules and alignment from the raw request
    div_operand_prep u_prep (
        .req  (req),
        .prep (prep)
    );

    // Iterative shift-and-subtract with sign fixup
    div_serial_core u_core (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .prep   (prep),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

endmodule

`default_nettype wire

// File: dv/div_unit_tb.sv
// Self-checking testbench for div_unit; checks live in assertions, stimulus is seeded and repeatable
`default_nettype none

module div_unit_tb import div_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Longest wait for done or idle, a little over the worst division
    localparam int done_limit = xlen + 4;

    logic            clk;
    logic            rst;
    logic            start;
    div_req_t        req;
    logic            busy;
    logic            done;
    logic [xlen-1:0] result;

    // Scoreboard, loaded on the edge that accepts a request
    logic [xlen-1:0] exp_q;
    logic            pending;
    int              lat;
    int              err_cnt;
    int              pass_cnt;
    int              fail_cnt;
    logic [31:0]     rng_state;

    div_unit DUT (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Operands biased toward zero, small, negative and the most negative value
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        logic [31:0] v;
        r = next_rand();
        v = next_rand();
        case (r[2:0])
            3'd0: return '0;
            3'd1: return v & 32'h0000_000f;
            3'd2: return 32'h8000_0000;
            3'd3: return -(v & 32'h0000_00ff);
            // A random width spreads the alignment shift over its range
            3'd4, 3'd5: return v >> r[7:3];
            default: return v;
        endcase
    endfunction

    // RISC-V division rules, truncating quotient and remainder signed like the dividend
    function automatic logic [xlen-1:0] ref_result(input div_op_e op,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        logic [xlen-1:0] q;
        logic [xlen-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (op == DIVU || op == REMU) begin
            q = a / b;
            r = a % b;
        end else if (a == {1'b1, {(xlen-1){1'b0}}} && b == '1) begin
            // Signed overflow returns the dividend and a zero remainder
            q = a;
            r = '0;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        return (op == REM || op == REMU) ? r : q;
    endfunction

    // Tracks the request in flight and the cycles since it was accepted
    always @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            lat     <= 0;
            exp_q   <= '0;
        end else if (start && !busy) begin
            pending <= 1'b1;
            lat     <= 0;
            exp_q   <= ref_result(req.op, req.dividend, req.divisor);
        end else if (done) begin
            pending <= 1'b0;
        end else if (pending) begin
            lat <= lat + 1;
        end
    end

    a_result: assert property (@(posedge clk) disable iff (rst) done |-> result == exp_q)
        else begin
            $display("Error at %0t: result %h, expected %h", $time, $sampled(result),
                     $sampled(exp_q));
            err_cnt++;
        end

    a_one_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $display("done stayed high for more than one cycle at %0t", $time);
            err_cnt++;
        end

    // Busy covers exactly the span from the accepting edge to the cycle after done
    a_busy_span: assert property (@(posedge clk) disable iff (rst) busy == pending)
        else begin
            $display("busy at %0t does not match the request in flight", $time);
            err_cnt++;
        end

    a_done_owner: assert property (@(posedge clk) disable iff (rst) done |-> pending)
        else begin
            $display("done at %0t without an accepted request", $time);
            err_cnt++;
        end

    a_latency: assert property (@(posedge clk) disable iff (rst) done |-> lat <= xlen)
        else begin
            $display("done at %0t came %0d cycles after the start", $time, $sampled(lat) + 1);
            err_cnt++;
        end

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < done_limit) begin
            @(posedge clk);
            n++;
        end
        if (busy) begin
            $display("busy did not fall within %0d cycles at %0t", done_limit, $time);
            err_cnt++;
        end
    endtask

    task automatic wait_done();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < done_limit) begin
            @(posedge clk);
            seen = done;
            n++;
        end
        if (!seen) begin
            $display("no done within %0d cycles at %0t", done_limit, $time);
            err_cnt++;
        end
    endtask

    task automatic run_div(input div_op_e op, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b);
        wait_idle();
        start        <= 1'b1;
        req.op       <= op;
        req.dividend <= a;
        req.divisor  <= b;
        @(posedge clk);
        start <= 1'b0;
        // Request lines only count in the start cycle
        req   <= {2'b01, next_rand(), next_rand()};
        wait_done();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        // Two more edges so the checks at and just after the last done have settled
        repeat (2) @(posedge clk);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int              base;
        logic [31:0]     r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        req       = '0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        rng_state = 32'hf912;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        base = err_cnt;
        @(posedge clk);
        a_reset: assert (!busy && !done && result == '0)
            else begin
                $display("Error at %0t: after reset busy %b done %b result %h", $time, busy,
                         done, result);
                err_cnt++;
            end
        finish_test("reset", base);

        // Divisor narrowed by s bits gives an alignment shift of exactly s
        base = err_cnt;
        for (int s = 0; s < xlen; s++) begin
            a = next_rand() | 32'h8000_0000;
            b = (next_rand() | 32'h8000_0000) >> s;
            run_div(DIVU, a, b);
            run_div(REMU, a, b);
            run_div(DIVU, b, a);
        end
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            run_div(div_op_e'({r[0], 1'b1}), pick_operand(), pick_operand());
        end
        finish_test("unsigned", base);

        // Loop index walks through all four sign combinations
        base = err_cnt;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            a = pick_operand() & 32'h7fff_ffff;
            b = pick_operand() & 32'h7fff_ffff;
            if (i[0]) begin
                a = -a;
            end
            if (i[1]) begin
                b = -b;
            end
            run_div(div_op_e'({r[0], 1'b0}), a, b);
        end
        run_div(DIV, 32'h8000_0000, '1);
        run_div(REM, 32'h8000_0000, '1);
        run_div(DIV, 32'h8000_0000, 32'h8000_0000);
        finish_test("signed", base);

        base = err_cnt;
        for (int i = 0; i < 8; i++) begin
            run_div(div_op_e'(i[1:0]), pick_operand(), '0);
        end
        finish_test("zero_divisor", base);

        // A shift of 30 keeps the first request busy while the second start arrives
        base = err_cnt;
        for (int i = 0; i < 4; i++) begin
            wait_idle();
            start        <= 1'b1;
            req.op       <= DIVU;
            req.dividend <= 32'hffff_fff0 ^ i;
            req.divisor  <= 32'd3;
            @(posedge clk);
            start <= 1'b0;
            repeat (2) @(posedge clk);
            start        <= 1'b1;
            req.op       <= div_op_e'(i[1:0]);
            req.dividend <= next_rand();
            req.divisor  <= 32'd7;
            repeat (3) @(posedge clk);
            start <= 1'b0;
            wait_done();
            repeat (4) @(posedge clk);
        end
        finish_test("start_while_busy", base);

        base = err_cnt;
        run_div(DIVU, 32'hffff_ffff, 32'd1);
        run_div(DIVU, 32'd0, 32'd1);
        for (int i = 0; i < 48; i++) begin
            r = next_rand();
            run_div(div_op_e'(r[1:0]), pick_operand(), pick_operand());
        end
        finish_test("latency", base);

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/div_pkg.sv
hdl/find_first_one.sv
hdl/div_operand_prep.sv
hdl/div_serial_core.sv
hdl/div_unit.sv
dv/div_unit_tb.sv

// File: Makefile
# Verilator build and run for the serial divider testbench

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Passes only when the simulation prints the pass message
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
